// File: logic/spi_byte_rx.svh
// spi byte receiver front end

// oversampled receiver state, all of it advances on clk_sys
typedef struct packed {
   logic [1:0] sck_s;     // two-flop synchronisers, [1] is the settled value
   logic [1:0] di_s;
   logic [1:0] ss_s;
   logic       sck_last;  // previous settled sck for edge detect
   logic [2:0] bit_cnt;
   logic [6:0] shreg;     // first seven bits of the byte, MSB first
} spi_rx_t;

localparam spi_rx_t SPI_RX_RESET = '{
   sck_s:    2'b00,
   di_s:     2'b00,
   ss_s:     2'b11,       // starts deselected
   sck_last: 1'b0,
   bit_cnt:  3'd0,
   shreg:    7'd0
};

// rising sck while the select is low
function automatic logic spi_rx_rise(input spi_rx_t rx);
   return rx.sck_s[1] & ~rx.sck_last & ~rx.ss_s[1];
endfunction

// eighth edge of a byte, valid for one cycle
function automatic logic spi_rx_done(input spi_rx_t rx);
   return spi_rx_rise(rx) && (rx.bit_cnt == 3'd7);
endfunction

function automatic spi_byte_t spi_rx_byte(input spi_rx_t rx);
   return {rx.shreg, rx.di_s[1]};
endfunction

function automatic spi_rx_t spi_rx_next(input spi_rx_t rx, input logic sck,
                                        input logic di, input logic ss);
   spi_rx_t nx;
   nx          = rx;
   nx.sck_s    = {rx.sck_s[0], sck};
   nx.di_s     = {rx.di_s[0], di};
   nx.ss_s     = {rx.ss_s[0], ss};
   nx.sck_last = rx.sck_s[1];
   if (rx.ss_s[1]) begin
      nx.bit_cnt = 3'd0;   // byte framing restarts with every select
   end else if (spi_rx_rise(rx)) begin
      nx.bit_cnt = rx.bit_cnt + 3'd1;
      nx.shreg   = {rx.shreg[5:0], rx.di_s[1]};
   end
   return nx;
endfunction

// File: logic/frame_cfg_pkg.sv
// frame control protocol types

package frame_cfg_pkg;

   // status and joystick words, most significant byte sent first
   typedef logic [31:0] cfg_word_t;

   // one byte as shifted in from the control processor
   typedef logic [7:0] spi_byte_t;

   // command codes, first byte of a frame on the configuration select
   localparam spi_byte_t CMD_STATUS = 8'h01;   // 4 payload bytes
   localparam spi_byte_t CMD_JOY1   = 8'h02;   // 4 payload bytes
   localparam spi_byte_t CMD_JOY2   = 8'h03;   // 4 payload bytes
   localparam spi_byte_t CMD_VIDEO  = 8'h04;   // 1 byte, bit 0 ypbpr, bit 1 scan2x off

   // opens a ROM download on the download select
   localparam spi_byte_t CMD_DOWNLOAD = 8'h5a;

endpackage

// File: logic/frame_av_pkg.sv
// frame audio and video types

package frame_av_pkg;

   // final colour channel as driven to the board DAC
   typedef logic [5:0] color6_t;

   // pcm sample from the game, signed or offset binary
   typedef logic [15:0] sample_t;

   // chroma mid level, centres Pb and Pr in the 6-bit range
   localparam color6_t YPBPR_OFFSET = 6'd32;

endpackage

// File: logic/spi_user_io.sv
// spi configuration receiver
`timescale 1ns/1ps

module spi_user_io
   import frame_cfg_pkg::*;
(
   input  logic      clk_sys,
   input  logic      rst_n_i,
   input  logic      spi_sck_i,
   input  logic      spi_di_i,
   input  logic      spi_ss_io_i,
   output cfg_word_t status_o,
   output cfg_word_t joystick1_o,
   output cfg_word_t joystick2_o,
   output logic      ypbpr_o,
   output logic      scan2x_enb_o
);

`include "spi_byte_rx.svh"

typedef enum logic [1:0] {IDLE, PAYLOAD, IGNORE} state_t;

spi_rx_t    rx_q;
state_t     state_q;
spi_byte_t  cmd_q;
logic [1:0] left_q;       // payload bytes still due minus one
cfg_word_t  payload_q;
logic       byte_done;
spi_byte_t  rx_byte;
cfg_word_t  word_next;
logic       commit;
logic       commit_status;
logic       commit_joy1;
logic       commit_joy2;
logic       commit_video;

assign byte_done = spi_rx_done(rx_q);
assign rx_byte   = spi_rx_byte(rx_q);
assign word_next = {payload_q[23:0], rx_byte};

// last byte of a frame lands this cycle
assign commit        = byte_done && (state_q == PAYLOAD) && (left_q == 2'd0);
assign commit_status = commit && (cmd_q == CMD_STATUS);
assign commit_joy1   = commit && (cmd_q == CMD_JOY1);
assign commit_joy2   = commit && (cmd_q == CMD_JOY2);
assign commit_video  = commit && (cmd_q == CMD_VIDEO);

always_ff @(posedge clk_sys) begin
   if (!rst_n_i) begin
      rx_q    <= SPI_RX_RESET;
      state_q <= IDLE;
      left_q  <= 2'd0;
   end else begin
      rx_q <= spi_rx_next(rx_q, spi_sck_i, spi_di_i, spi_ss_io_i);
      if (rx_q.ss_s[1]) begin
         state_q <= IDLE;
      end else if (byte_done) begin
         case (state_q)
            IDLE: begin
               case (rx_byte)
                  CMD_STATUS, CMD_JOY1, CMD_JOY2: begin
                     state_q <= PAYLOAD;
                     left_q  <= 2'd3;
                  end
                  CMD_VIDEO: begin
                     state_q <= PAYLOAD;
                     left_q  <= 2'd0;
                  end
                  default: state_q <= IGNORE;   // unknown command waits for deselect
               endcase
            end
            PAYLOAD: begin
               if (left_q == 2'd0)
                  state_q <= IGNORE;   // extra bytes are dropped
               left_q <= left_q - 2'd1;
            end
            default: ;
         endcase
      end
   end
end

always_ff @(posedge clk_sys) begin
   if (byte_done && (state_q == IDLE))
      cmd_q <= rx_byte;
   if (byte_done && (state_q == PAYLOAD))
      payload_q <= word_next;
end

always_ff @(posedge clk_sys) begin
   if (!rst_n_i) begin
      status_o     <= '0;
      joystick1_o  <= '0;
      joystick2_o  <= '0;
      ypbpr_o      <= 1'b0;
      scan2x_enb_o <= 1'b0;
   end else begin
      if (commit_status) status_o    <= word_next;
      if (commit_joy1)   joystick1_o <= word_next;
      if (commit_joy2)   joystick2_o <= word_next;
      if (commit_video) begin
         ypbpr_o      <= rx_byte[0];
         scan2x_enb_o <= rx_byte[1];
      end
   end
end

// a finished frame always carries a known command, so exactly one register takes it
a_one_commit: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
   commit |-> $onehot({commit_status, commit_joy1, commit_joy2, commit_video}));

endmodule

// File: logic/spi_data_io.sv
// spi rom download receiver
`timescale 1ns/1ps

module spi_data_io
   import frame_cfg_pkg::*;
#(
   parameter int ADDR_W = 25
) (
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  logic              spi_sck_i,
   input  logic              spi_di_i,
   input  logic              spi_ss_dl_i,
   output logic [ADDR_W-1:0] ioctl_addr_o,
   output spi_byte_t         ioctl_data_o,
   output logic              ioctl_wr_o,
   output logic              downloading_o
);

`include "spi_byte_rx.svh"

typedef enum logic [1:0] {WAIT_CMD, ACTIVE, SKIP} state_t;

spi_rx_t   rx_q;
state_t    state_q;
logic      byte_done;
spi_byte_t rx_byte;

assign byte_done     = spi_rx_done(rx_q);
assign rx_byte       = spi_rx_byte(rx_q);
assign downloading_o = (state_q == ACTIVE);

always_ff @(posedge clk_sys) begin
   if (!rst_n_i) begin
      rx_q         <= SPI_RX_RESET;
      state_q      <= WAIT_CMD;
      ioctl_wr_o   <= 1'b0;
      ioctl_addr_o <= '0;
   end else begin
      rx_q       <= spi_rx_next(rx_q, spi_sck_i, spi_di_i, spi_ss_dl_i);
      ioctl_wr_o <= 1'b0;
      if (ioctl_wr_o)
         ioctl_addr_o <= ioctl_addr_o + ADDR_W'(1);   // step once the write is out
      if (rx_q.ss_s[1]) begin
         state_q <= WAIT_CMD;   // download ends with the select
      end else if (byte_done) begin
         case (state_q)
            WAIT_CMD: begin
               if (rx_byte == CMD_DOWNLOAD) begin
                  state_q      <= ACTIVE;
                  ioctl_addr_o <= '0;
               end else begin
                  state_q <= SKIP;   // no opening command, whole frame dropped
               end
            end
            ACTIVE:  ioctl_wr_o <= 1'b1;
            default: ;
         endcase
      end
   end
end

// data byte held until the next one
always_ff @(posedge clk_sys) begin
   if (byte_done && (state_q == ACTIVE))
      ioctl_data_o <= rx_byte;
end

a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
   ioctl_wr_o |-> downloading_o);

endmodule

// File: logic/sigma_delta_dac.sv
// first-order sigma-delta audio dac
`timescale 1ns/1ps

module sigma_delta_dac
   import frame_av_pkg::*;
#(
   parameter bit SIGNED_SND = 1'b1
) (
   input  logic    clk_sys,
   input  logic    rst_n_i,
   input  sample_t pcm_i,
   output logic    dac_o
);

// accumulator with the carry on top
typedef logic [16:0] acc_t;

sample_t pcm_ofs;
acc_t    acc_q;

// two's complement to offset binary by flipping the sign bit
assign pcm_ofs = {pcm_i[15] ^ SIGNED_SND, pcm_i[14:0]};

always_ff @(posedge clk_sys) begin
   if (!rst_n_i) begin
      acc_q <= '0;
   end else begin
      // carry is dropped back out every cycle
      acc_q <= acc_t'(acc_q[15:0]) + acc_t'(pcm_ofs);
   end
end

assign dac_o = acc_q[16];   // pulse density follows the sample level

endmodule

// File: logic/video_out_mux.sv
// final video select and ypbpr encoder
`timescale 1ns/1ps

module video_out_mux
   import frame_av_pkg::*;
#(
   parameter int COLORW = 4
) (
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  logic [COLORW-1:0] game_r_i,
   input  logic [COLORW-1:0] game_g_i,
   input  logic [COLORW-1:0] game_b_i,
   input  logic              game_hs_i,
   input  logic              game_vs_i,
   input  color6_t           scan2x_r_i,
   input  color6_t           scan2x_g_i,
   input  color6_t           scan2x_b_i,
   input  logic              scan2x_hs_i,
   input  logic              scan2x_vs_i,
   input  logic              scan2x_enb_i,
   input  logic              ypbpr_i,
   output color6_t           video_r_o,
   output color6_t           video_g_o,
   output color6_t           video_b_o,
   output logic              video_hs_o,
   output logic              video_vs_o
);

if (COLORW < 3 || COLORW > 8) begin : g_bad_colorw
   $error("video_out_mux: COLORW must lie in 3 to 8");
end

localparam logic signed [15:0] OFS_S = 16'(YPBPR_OFFSET);

// game bits on top, top bits repeated below
function automatic color6_t widen(input logic [COLORW-1:0] c);
   color6_t w;
   for (int i = 0; i < 6; i++) begin
      w[5-i] = c[COLORW-1-(i % COLORW)];
   end
   return w;
endfunction

function automatic color6_t clamp6(input logic signed [15:0] v);
   if (v < 16'sd0)
      return 6'd0;
   if (v > 16'sd63)
      return 6'd63;
   return v[5:0];
endfunction

color6_t            src_r;
color6_t            src_g;
color6_t            src_b;
logic               src_hs;
logic               src_vs;
logic               csync;
logic signed [15:0] r_s;
logic signed [15:0] g_s;
logic signed [15:0] b_s;
logic signed [15:0] y_sum;
logic signed [15:0] pb_sum;
logic signed [15:0] pr_sum;

always_comb begin
   src_r  = scan2x_enb_i ? widen(game_r_i) : scan2x_r_i;
   src_g  = scan2x_enb_i ? widen(game_g_i) : scan2x_g_i;
   src_b  = scan2x_enb_i ? widen(game_b_i) : scan2x_b_i;
   src_hs = scan2x_enb_i ? ~game_hs_i : scan2x_hs_i;   // game syncs are active high
   src_vs = scan2x_enb_i ? ~game_vs_i : scan2x_vs_i;
   csync  = ~(src_hs ^ src_vs);
end

always_comb begin
   r_s    = signed'({10'd0, src_r});
   g_s    = signed'({10'd0, src_g});
   b_s    = signed'({10'd0, src_b});
   y_sum  = 16'sd77 * r_s + 16'sd150 * g_s + 16'sd29 * b_s;
   pb_sum = 16'sd128 * b_s - 16'sd43 * r_s - 16'sd85 * g_s;
   pr_sum = 16'sd128 * r_s - 16'sd107 * g_s - 16'sd21 * b_s;
end

always_ff @(posedge clk_sys) begin
   if (!rst_n_i) begin
      video_r_o  <= '0;
      video_g_o  <= '0;
      video_b_o  <= '0;
      video_hs_o <= 1'b0;
      video_vs_o <= 1'b0;
   end else begin
      if (ypbpr_i) begin
         video_r_o <= clamp6((pr_sum >>> 8) + OFS_S);   // Pr on red
         video_g_o <= clamp6(y_sum >>> 8);              // Y on green
         video_b_o <= clamp6((pb_sum >>> 8) + OFS_S);   // Pb on blue
      end else begin
         video_r_o <= src_r;
         video_g_o <= src_g;
         video_b_o <= src_b;
      end
      // scart and component want composite sync, vs tied high
      video_hs_o <= (scan2x_enb_i | ypbpr_i) ? csync : src_hs;
      video_vs_o <= (scan2x_enb_i | ypbpr_i) ? 1'b1  : src_vs;
   end
end

endmodule

// File: logic/frame_base.sv
// retro core frame base layer
`timescale 1ns/1ps

module frame_base
   import frame_cfg_pkg::*, frame_av_pkg::*;
#(
   parameter int COLORW     = 4,
   parameter bit SIGNED_SND = 1'b1,
   parameter bit STEREO     = 1'b0,
   parameter int ADDR_W     = 25
) (
   input  logic              clk_sys,
   input  logic              rst_n_i,
   input  logic              spi_sck_i,
   input  logic              spi_di_i,
   input  logic              spi_ss_io_i,
   input  logic              spi_ss_dl_i,
   output cfg_word_t         status_o,
   output cfg_word_t         joystick1_o,
   output cfg_word_t         joystick2_o,
   output logic              ypbpr_o,
   output logic              scan2x_enb_o,   // also turns the outside doubler off
   output logic [ADDR_W-1:0] ioctl_addr_o,
   output spi_byte_t         ioctl_data_o,
   output logic              ioctl_wr_o,
   output logic              downloading_o,
   input  logic [COLORW-1:0] game_r_i,
   input  logic [COLORW-1:0] game_g_i,
   input  logic [COLORW-1:0] game_b_i,
   input  logic              game_hs_i,
   input  logic              game_vs_i,
   input  color6_t           scan2x_r_i,
   input  color6_t           scan2x_g_i,
   input  color6_t           scan2x_b_i,
   input  logic              scan2x_hs_i,
   input  logic              scan2x_vs_i,
   input  sample_t           snd_left_i,
   input  sample_t           snd_right_i,
   output logic              snd_left_o,
   output logic              snd_right_o,
   output color6_t           video_r_o,
   output color6_t           video_g_o,
   output color6_t           video_b_o,
   output logic              video_hs_o,
   output logic              video_vs_o
);

spi_user_io u_user_io (
   .clk_sys      ( clk_sys      ),
   .rst_n_i      ( rst_n_i      ),
   .spi_sck_i    ( spi_sck_i    ),
   .spi_di_i     ( spi_di_i     ),
   .spi_ss_io_i  ( spi_ss_io_i  ),
   .status_o     ( status_o     ),
   .joystick1_o  ( joystick1_o  ),
   .joystick2_o  ( joystick2_o  ),
   .ypbpr_o      ( ypbpr_o      ),
   .scan2x_enb_o ( scan2x_enb_o )
);

spi_data_io #(.ADDR_W(ADDR_W)) u_data_io (
   .clk_sys       ( clk_sys       ),
   .rst_n_i       ( rst_n_i       ),
   .spi_sck_i     ( spi_sck_i     ),
   .spi_di_i      ( spi_di_i      ),
   .spi_ss_dl_i   ( spi_ss_dl_i   ),
   .ioctl_addr_o  ( ioctl_addr_o  ),
   .ioctl_data_o  ( ioctl_data_o  ),
   .ioctl_wr_o    ( ioctl_wr_o    ),
   .downloading_o ( downloading_o )
);

sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_left (
   .clk_sys ( clk_sys    ),
   .rst_n_i ( rst_n_i    ),
   .pcm_i   ( snd_left_i ),
   .dac_o   ( snd_left_o )
);

if (STEREO) begin : g_stereo
   sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_right (
      .clk_sys ( clk_sys     ),
      .rst_n_i ( rst_n_i     ),
      .pcm_i   ( snd_right_i ),
      .dac_o   ( snd_right_o )
   );
end else begin : g_mono
   assign snd_right_o = snd_left_o;   // mono game, same bit on both sides
end

video_out_mux #(.COLORW(COLORW)) u_video (
   .clk_sys      ( clk_sys      ),
   .rst_n_i      ( rst_n_i      ),
   .game_r_i     ( game_r_i     ),
   .game_g_i     ( game_g_i     ),
   .game_b_i     ( game_b_i     ),
   .game_hs_i    ( game_hs_i    ),
   .game_vs_i    ( game_vs_i    ),
   .scan2x_r_i   ( scan2x_r_i   ),
   .scan2x_g_i   ( scan2x_g_i   ),
   .scan2x_b_i   ( scan2x_b_i   ),
   .scan2x_hs_i  ( scan2x_hs_i  ),
   .scan2x_vs_i  ( scan2x_vs_i  ),
   .scan2x_enb_i ( scan2x_enb_o ),
   .ypbpr_i      ( ypbpr_o      ),
   .video_r_o    ( video_r_o    ),
   .video_g_o    ( video_g_o    ),
   .video_b_o    ( video_b_o    ),
   .video_hs_o   ( video_hs_o   ),
   .video_vs_o   ( video_vs_o   )
);

endmodule

// File: bench/spi_tasks.svh
// spi frame tasks for the testbench
`ifndef SPI_TASKS_SVH
`define SPI_TASKS_SVH

localparam int SCK_HALF = 4;   // clk_sys cycles per sck phase

task automatic wait_cycles(input int n);
   repeat (n) @(negedge clk_sys);
endtask

// mode 0, msb first, data set up while sck is low
task automatic shift_byte(input spi_byte_t b);
   spi_byte_t sh;
   sh = b;
   repeat (8) begin
      spi_sck_i = 1'b0;
      spi_di_i  = sh[7];
      wait_cycles(SCK_HALF);
      spi_sck_i = 1'b1;
      wait_cycles(SCK_HALF);
      sh = sh << 1;
   end
endtask

task automatic open_frame(input logic dl);
   if (dl)
      spi_ss_dl_i = 1'b0;
   else
      spi_ss_io_i = 1'b0;
   wait_cycles(SCK_HALF);
endtask

// sck back low, then a deselect long enough for both synchronisers
task automatic close_frame();
   spi_sck_i = 1'b0;
   wait_cycles(SCK_HALF);
   spi_ss_io_i = 1'b1;
   spi_ss_dl_i = 1'b1;
   wait_cycles(2 * SCK_HALF);
endtask

function automatic int payload_len(input spi_byte_t cmd);
   return (cmd == CMD_VIDEO) ? 1 : 4;
endfunction

// command, then the first sent bytes of a payload of total bytes
task automatic send_cfg(input spi_byte_t cmd, input cfg_word_t word,
                        input int total, input int sent);
   open_frame(1'b0);
   shift_byte(cmd);
   for (int i = 0; i < sent; i++)
      shift_byte(spi_byte_t'(word >> (8 * (total - 1 - i))));   // msb first
   close_frame();
endtask

`endif

// File: bench/frame_base_tb.sv
// frame base testbench
`timescale 1ns/1ps

module frame_base_tb
   import frame_cfg_pkg::*, frame_av_pkg::*;
();

localparam int COLORW     = 4;
localparam bit SIGNED_SND = 1'b1;
localparam bit STEREO     = 1'b0;
localparam int ADDR_W     = 25;
localparam int N_CFG      = 20;
localparam int N_CUT      = 3;
localparam int N_DL       = 64;
localparam int N_SKIP     = 4;
localparam int N_SMP      = 16;
localparam int SMP_HOLD   = 64;
localparam int N_VID      = 24;

logic              clk_sys = 1'b0;
logic              rst_n_i;
logic              spi_sck_i;
logic              spi_di_i;
logic              spi_ss_io_i;
logic              spi_ss_dl_i;
cfg_word_t         status_o;
cfg_word_t         joystick1_o;
cfg_word_t         joystick2_o;
logic              ypbpr_o;
logic              scan2x_enb_o;
logic [ADDR_W-1:0] ioctl_addr_o;
spi_byte_t         ioctl_data_o;
logic              ioctl_wr_o;
logic              downloading_o;
logic [COLORW-1:0] game_r_i;
logic [COLORW-1:0] game_g_i;
logic [COLORW-1:0] game_b_i;
logic              game_hs_i;
logic              game_vs_i;
color6_t           scan2x_r_i;
color6_t           scan2x_g_i;
color6_t           scan2x_b_i;
logic              scan2x_hs_i;
logic              scan2x_vs_i;
sample_t           snd_left_i;
sample_t           snd_right_i;
logic              snd_left_o;
logic              snd_right_o;
color6_t           video_r_o;
color6_t           video_g_o;
color6_t           video_b_o;
logic              video_hs_o;
logic              video_vs_o;

// reference state
cfg_word_t   m_status = '0;
cfg_word_t   m_joy1   = '0;
cfg_word_t   m_joy2   = '0;
logic        m_ypbpr  = 1'b0;
logic        m_scan2x = 1'b0;
logic [16:0] dac_acc;
spi_byte_t   dl_mem [N_DL];
int          wr_cnt       = 0;
int          err_cnt      = 0;
int          tests_run    = 0;
int          tests_passed = 0;
int          cycle_cnt    = 0;

frame_base #(
   .COLORW(COLORW), .SIGNED_SND(SIGNED_SND), .STEREO(STEREO), .ADDR_W(ADDR_W)
) uut (.*);

`include "spi_tasks.svh"

localparam int BYTE_CYC    = 16 * SCK_HALF;
localparam int FRAME_OVH   = 4 * SCK_HALF;
localparam int CFG_CYC     = N_CFG * (5 * BYTE_CYC + FRAME_OVH)
                             + N_CUT * (4 * BYTE_CYC + FRAME_OVH);
localparam int DL_CYC      = (2 + N_DL + N_SKIP) * BYTE_CYC + 2 * FRAME_OVH;
localparam int VID_CYC     = 3 * (2 * BYTE_CYC + FRAME_OVH) + 3 * N_VID;
localparam int TIMEOUT_CYC = 2 * (5 + CFG_CYC + DL_CYC + N_SMP * SMP_HOLD + VID_CYC);

always #5 clk_sys = ~clk_sys;

always @(posedge clk_sys) begin
   cycle_cnt <= cycle_cnt + 1;
   if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Test failures found");
      $finish;
   end
end

// dac reference accumulator stepping from reset with the DUT
always @(posedge clk_sys) begin
   if (!rst_n_i)
      dac_acc <= '0;
   else
      dac_acc <= {1'b0, dac_acc[15:0]} + {1'b0, snd_left_i ^ {SIGNED_SND, 15'd0}};
end

// every write strobe against the byte sent at that position
always @(negedge clk_sys) begin
   if (rst_n_i && ioctl_wr_o) begin
      if (wr_cnt >= N_DL) begin
         $display("FAIL %0t: unexpected write strobe at address %h", $time, ioctl_addr_o);
         err_cnt++;
      end else if (ioctl_addr_o !== ADDR_W'(wr_cnt) || ioctl_data_o !== dl_mem[wr_cnt[5:0]]
                   || !downloading_o) begin
         $display("FAIL %0t: write %h=%h dl %b, expected %h=%h dl 1", $time, ioctl_addr_o,
                  ioctl_data_o, downloading_o, wr_cnt, dl_mem[wr_cnt[5:0]]);
         err_cnt++;
      end
      wr_cnt++;
   end
end

function automatic spi_byte_t pick_cmd(input int sel);
   case (sel)
      0:       return CMD_STATUS;
      1:       return CMD_JOY1;
      2:       return CMD_JOY2;
      default: return CMD_VIDEO;
   endcase
endfunction

// game bits repeated and the top six kept
function automatic color6_t widen_game(input logic [COLORW-1:0] c);
   logic [3*COLORW-1:0] rep;
   rep = {3{c}};
   return rep[3*COLORW-1 -: 6];
endfunction

function automatic color6_t scale_clamp(input int sum, input int ofs);
   int v;
   v = (sum >>> 8) + ofs;
   if (v < 0)
      return '0;
   if (v > 63)
      return 6'd63;
   return color6_t'(v);
endfunction

task automatic update_model(input spi_byte_t cmd, input cfg_word_t word);
   case (cmd)
      CMD_STATUS: m_status = word;
      CMD_JOY1:   m_joy1   = word;
      CMD_JOY2:   m_joy2   = word;
      CMD_VIDEO: begin
         m_ypbpr  = word[0];
         m_scan2x = word[1];
      end
      default: ;
   endcase
endtask

task automatic check_regs();
   if (status_o !== m_status || joystick1_o !== m_joy1 || joystick2_o !== m_joy2) begin
      $display("FAIL %0t: status %h joy1 %h joy2 %h, expected %h %h %h", $time,
               status_o, joystick1_o, joystick2_o, m_status, m_joy1, m_joy2);
      err_cnt++;
   end
   if (ypbpr_o !== m_ypbpr || scan2x_enb_o !== m_scan2x) begin
      $display("FAIL %0t: ypbpr %b scan2x_enb %b, expected %b %b", $time,
               ypbpr_o, scan2x_enb_o, m_ypbpr, m_scan2x);
      err_cnt++;
   end
endtask

task automatic check_video(input color6_t er, input color6_t eg, input color6_t eb,
                           input logic ehs, input logic evs);
   if (video_r_o !== er || video_g_o !== eg || video_b_o !== eb
       || video_hs_o !== ehs || video_vs_o !== evs) begin
      $display("FAIL %0t: rgb %h %h %h hs %b vs %b, expected %h %h %h hs %b vs %b", $time,
               video_r_o, video_g_o, video_b_o, video_hs_o, video_vs_o, er, eg, eb, ehs, evs);
      err_cnt++;
   end
endtask

task automatic report_test(input string name, input int errs_before);
   tests_run++;
   if (err_cnt == errs_before) begin
      tests_passed++;
      $display("pass %0t: %s", $time, name);
   end else begin
      $display("FAIL %0t: %s, %0d checks failed", $time, name, err_cnt - errs_before);
   end
endtask

task automatic set_video_flags(input spi_byte_t flags);
   send_cfg(CMD_VIDEO, cfg_word_t'(flags), 1, 1);
   update_model(CMD_VIDEO, cfg_word_t'(flags));
   check_regs();
endtask

task automatic drive_video();
   game_r_i    = COLORW'($urandom());
   game_g_i    = COLORW'($urandom());
   game_b_i    = COLORW'($urandom());
   game_hs_i   = 1'($urandom());
   game_vs_i   = 1'($urandom());
   scan2x_r_i  = color6_t'($urandom());
   scan2x_g_i  = color6_t'($urandom());
   scan2x_b_i  = color6_t'($urandom());
   scan2x_hs_i = 1'($urandom());
   scan2x_vs_i = 1'($urandom());
endtask

task automatic test_config();
   int        errs;
   spi_byte_t cmd;
   cfg_word_t word;
   errs = err_cnt;
   check_regs();   // reset values
   for (int i = 0; i < N_CFG; i++) begin
      cmd  = pick_cmd($urandom_range(0, 3));
      word = $urandom();
      send_cfg(cmd, word, payload_len(cmd), payload_len(cmd));
      update_model(cmd, word);
      check_regs();
   end
   for (int i = 0; i < N_CUT; i++) begin
      cmd  = pick_cmd($urandom_range(0, 2));
      word = $urandom();
      send_cfg(cmd, word, 4, $urandom_range(0, 3));   // select rises before the last byte
      check_regs();
   end
   report_test("config frames", errs);
endtask

task automatic test_download();
   int        errs;
   spi_byte_t first;
   errs = err_cnt;
   for (int i = 0; i < N_DL; i++)
      dl_mem[i[5:0]] = spi_byte_t'($urandom());
   wr_cnt = 0;
   open_frame(1'b1);
   shift_byte(CMD_DOWNLOAD);
   for (int i = 0; i < N_DL; i++) begin
      if (downloading_o !== 1'b1) begin
         $display("FAIL %0t: downloading_o low during the download", $time);
         err_cnt++;
      end
      shift_byte(dl_mem[i[5:0]]);
   end
   close_frame();
   if (downloading_o !== 1'b0 || wr_cnt != N_DL) begin
      $display("FAIL %0t: dl %b after select, %0d strobes, expected 0 and %0d", $time,
               downloading_o, wr_cnt, N_DL);
      err_cnt++;
   end
   first = spi_byte_t'($urandom());
   if (first == CMD_DOWNLOAD)
      first = ~first;
   open_frame(1'b1);
   shift_byte(first);   // no opening command so the monitor flags any strobe
   repeat (N_SKIP) shift_byte(spi_byte_t'($urandom()));
   close_frame();
   report_test("rom download", errs);
endtask

task automatic test_dac();
   int errs;
   errs = err_cnt;
   for (int s = 0; s < N_SMP; s++) begin
      snd_left_i  = sample_t'($urandom());
      snd_right_i = sample_t'($urandom());
      for (int c = 0; c < SMP_HOLD; c++) begin
         wait_cycles(1);
         if (snd_left_o !== dac_acc[16]) begin
            $display("FAIL %0t: dac bit %b, expected %b", $time, snd_left_o, dac_acc[16]);
            err_cnt++;
         end
         if (!STEREO && snd_right_o !== snd_left_o) begin
            $display("FAIL %0t: right bit %b differs from left", $time, snd_right_o);
            err_cnt++;
         end
      end
   end
   report_test("sigma-delta audio", errs);
endtask

task automatic test_game_video();
   int errs;
   errs = err_cnt;
   set_video_flags(8'h02);   // doubler off and rgb out
   for (int i = 0; i < N_VID; i++) begin
      drive_video();
      wait_cycles(1);
      check_video(widen_game(game_r_i), widen_game(game_g_i), widen_game(game_b_i),
                  ~((~game_hs_i) ^ (~game_vs_i)), 1'b1);
   end
   report_test("game video", errs);
endtask

task automatic test_scan2x_video();
   int errs;
   int r;
   int g;
   int b;
   errs = err_cnt;
   set_video_flags(8'h00);
   for (int i = 0; i < N_VID; i++) begin
      drive_video();
      wait_cycles(1);
      check_video(scan2x_r_i, scan2x_g_i, scan2x_b_i, scan2x_hs_i, scan2x_vs_i);
   end
   set_video_flags(8'h01);
   for (int i = 0; i < N_VID; i++) begin
      drive_video();
      wait_cycles(1);
      r = int'(scan2x_r_i);
      g = int'(scan2x_g_i);
      b = int'(scan2x_b_i);
      check_video(scale_clamp(128 * r - 107 * g - 21 * b, int'(YPBPR_OFFSET)),   // Pr
                  scale_clamp(77 * r + 150 * g + 29 * b, 0),                     // Y
                  scale_clamp(128 * b - 43 * r - 85 * g, int'(YPBPR_OFFSET)),    // Pb
                  ~(scan2x_hs_i ^ scan2x_vs_i), 1'b1);
   end
   report_test("doubler video and ypbpr", errs);
endtask

initial begin
   void'($urandom(32'hcf8));
   rst_n_i     = 1'b0;
   spi_sck_i   = 1'b0;
   spi_di_i    = 1'b0;
   spi_ss_io_i = 1'b1;
   spi_ss_dl_i = 1'b1;
   snd_left_i  = '0;
   snd_right_i = '0;
   game_r_i    = '0;
   game_g_i    = '0;
   game_b_i    = '0;
   game_hs_i   = 1'b0;
   game_vs_i   = 1'b0;
   scan2x_r_i  = '0;
   scan2x_g_i  = '0;
   scan2x_b_i  = '0;
   scan2x_hs_i = 1'b0;
   scan2x_vs_i = 1'b0;
   wait_cycles(5);
   rst_n_i = 1'b1;
   test_config();
   test_download();
   test_dac();
   test_game_video();
   test_scan2x_video();
   $display("%0d of %0d tests passed, %0d failed checks", tests_passed, tests_run, err_cnt);
   if (err_cnt == 0)
      $display("All tests passed!");
   else
      $display("Test failures found");
   $finish;
end

endmodule

// File: files.f
+incdir+logic
+incdir+bench
logic/frame_cfg_pkg.sv
logic/frame_av_pkg.sv
logic/spi_user_io.sv
logic/spi_data_io.sv
logic/sigma_delta_dac.sv
logic/video_out_mux.sv
logic/frame_base.sv
bench/frame_base_tb.sv

// File: Makefile
# Verilator build and run for the frame base testbench

VERILATOR  ?= verilator
TOP        ?= frame_base_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
